// ==== axi_tst.f ====
axi_tst_pkg.sv
axi_tst_cfg_port.sv
axi_tst_addr_chan.sv
axi_tst_wdata_chan.sv
axi_tst_bresp_chan.sv
axi_tst_rdata_chan.sv
axi_tst.sv
tb_axi_tst.sv

// ==== axi_tst.sv ====
`timescale 1ns/1ns
module axi_tst
(
   input  logic                   clk,
   input  logic                   sync_rst_n,
   input  axi_tst_pkg::cfg_word_t cfg_addr,
   input  axi_tst_pkg::cfg_word_t cfg_wdata,
   input  logic                   cfg_wr,
   input  logic                   cfg_rd,
   output logic                   tst_cfg_ack,
   output axi_tst_pkg::cfg_word_t tst_cfg_rdata,

   output logic                   awvalid,
   output axi_tst_pkg::axi_addr_t awaddr,
   output axi_tst_pkg::axi_len_t  awlen,
   output axi_tst_pkg::axi_id_t   awid,
   input  logic                   awready,

   output logic                   wvalid,
   output axi_tst_pkg::axi_data_t wdata,
   output axi_tst_pkg::axi_strb_t wstrb,
   output logic                   wlast,
   output axi_tst_pkg::axi_id_t   wid,
   input  logic                   wready,

   input  logic                   bvalid,
   input  axi_tst_pkg::axi_resp_t bresp,
   input  axi_tst_pkg::axi_id_t   bid,
   output logic                   bready,

   output logic                   arvalid,
   output axi_tst_pkg::axi_addr_t araddr,
   output axi_tst_pkg::axi_len_t  arlen,
   output axi_tst_pkg::axi_id_t   arid,
   input  logic                   arready,

   input  logic                   rvalid,
   input  axi_tst_pkg::axi_data_t rdata,
   input  axi_tst_pkg::axi_resp_t rresp,
   input  logic                   rlast,
   input  axi_tst_pkg::axi_id_t   rid,
   output logic                   rready
);

   axi_tst_pkg::cfg_addr_t cfg_addr_q;
   axi_tst_pkg::cfg_word_t cfg_wdata_q;
   logic                   wr_stb;
   logic                   rd_stb;
   axi_tst_pkg::cfg_word_t aw_rdata, w_rdata, b_rdata, ar_rdata, r_rdata;
   logic                   aw_rd_hit, w_rd_hit, b_rd_hit, ar_rd_hit, r_rd_hit;

   axi_tst_cfg_port u_cfg_port (.*);

   axi_tst_addr_chan #(.CHAN_BASE(axi_tst_pkg::AW_BASE)) u_aw_chan
   (
      .*,
      .ready  (awready),
      .valid  (awvalid),
      .addr   (awaddr),
      .len    (awlen),
      .id     (awid),
      .rdata  (aw_rdata),
      .rd_hit (aw_rd_hit)
   );

   axi_tst_wdata_chan u_w_chan (.*, .rdata(w_rdata), .rd_hit(w_rd_hit));

   axi_tst_bresp_chan u_b_chan (.*, .rdata(b_rdata), .rd_hit(b_rd_hit));

   axi_tst_addr_chan #(.CHAN_BASE(axi_tst_pkg::AR_BASE)) u_ar_chan
   (
      .*,
      .ready  (arready),
      .valid  (arvalid),
      .addr   (araddr),
      .len    (arlen),
      .id     (arid),
      .rdata  (ar_rdata),
      .rd_hit (ar_rd_hit)
   );

   axi_tst_rdata_chan u_r_chan (.*, .rdata_in(rdata), .rdata(r_rdata), .rd_hit(r_rd_hit));

endmodule

// ==== axi_tst_addr_chan.sv ====
`timescale 1ns/1ns
module axi_tst_addr_chan
#(
   parameter axi_tst_pkg::cfg_addr_t CHAN_BASE = axi_tst_pkg::AW_BASE
)
(
   input  logic                   clk,
   input  logic                   sync_rst_n,
   input  axi_tst_pkg::cfg_addr_t cfg_addr_q,
   input  axi_tst_pkg::cfg_word_t cfg_wdata_q,
   input  logic                   wr_stb,
   input  logic                   ready,
   output logic                   valid,
   output axi_tst_pkg::axi_addr_t addr,
   output axi_tst_pkg::axi_len_t  len,
   output axi_tst_pkg::axi_id_t   id,
   output axi_tst_pkg::cfg_word_t rdata,
   output logic                   rd_hit
);

   logic done;
   logic wr_ctrl;

   assign wr_ctrl = wr_stb && (cfg_addr_q == CHAN_BASE + axi_tst_pkg::OFS_CTRL);

   // Valid holds until the slave takes it; the handshake beats a done clear
   always_ff @(posedge clk)
      if (!sync_rst_n)
      begin
         valid <= 1'b0;
         done  <= 1'b0;
      end
      else
      begin
         if (wr_ctrl && cfg_wdata_q[axi_tst_pkg::CTRL_SET_BIT])
            valid <= 1'b1;
         else if (valid && ready)
            valid <= 1'b0;
         if (valid && ready)
            done <= 1'b1;
         else if (wr_ctrl && cfg_wdata_q[axi_tst_pkg::CTRL_DONE_BIT])
            done <= 1'b0;
      end

   // Payload goes straight out on the AXI side
   always_ff @(posedge clk)
      if (!sync_rst_n)
      begin
         addr <= '0;
         len  <= '0;
         id   <= '0;
      end
      else if (wr_stb && (cfg_addr_q == CHAN_BASE + axi_tst_pkg::OFS_ADDR))
         addr <= cfg_wdata_q;
      else if (wr_stb && (cfg_addr_q == CHAN_BASE + axi_tst_pkg::OFS_LEN_ID))
         {id, len} <= cfg_wdata_q[axi_tst_pkg::ID_WIDTH+axi_tst_pkg::LEN_WIDTH-1:0];

   always_ff @(posedge clk)
      if (!sync_rst_n)
      begin
         rd_hit <= 1'b0;
         rdata  <= '0;
      end
      else
      begin
         rd_hit <= 1'b1;
         case (cfg_addr_q)
            CHAN_BASE + axi_tst_pkg::OFS_CTRL:   rdata <= {30'd0, done, valid};
            CHAN_BASE + axi_tst_pkg::OFS_ADDR:   rdata <= addr;
            CHAN_BASE + axi_tst_pkg::OFS_LEN_ID: rdata <= axi_tst_pkg::cfg_word_t'({id, len});
            default:
            begin
               rd_hit <= 1'b0;
               rdata  <= '0;
            end
         endcase
      end

   valid_held: assert property (@(posedge clk) disable iff (!sync_rst_n)
      valid && !ready |=> valid);

endmodule

// ==== axi_tst_bresp_chan.sv ====
`timescale 1ns/1ns
module axi_tst_bresp_chan
(
   input  logic                   clk,
   input  logic                   sync_rst_n,
   input  axi_tst_pkg::cfg_addr_t cfg_addr_q,
   input  axi_tst_pkg::cfg_word_t cfg_wdata_q,
   input  logic                   wr_stb,
   input  logic                   bvalid,
   input  axi_tst_pkg::axi_resp_t bresp,
   input  axi_tst_pkg::axi_id_t   bid,
   output logic                   bready,
   output axi_tst_pkg::cfg_word_t rdata,
   output logic                   rd_hit
);

   logic                   done;
   logic                   wr_ctrl;
   axi_tst_pkg::axi_resp_t b_resp;
   axi_tst_pkg::axi_id_t   b_id;

   assign wr_ctrl = wr_stb && (cfg_addr_q == axi_tst_pkg::REG_B_CTRL);

   // Ready accepts a single response, whose fields are kept for the host
   always_ff @(posedge clk)
      if (!sync_rst_n)
      begin
         bready <= 1'b0;
         done   <= 1'b0;
         b_resp <= '0;
         b_id   <= '0;
      end
      else
      begin
         if (wr_ctrl && cfg_wdata_q[axi_tst_pkg::CTRL_SET_BIT])
            bready <= 1'b1;
         else if (bvalid && bready)
            bready <= 1'b0;
         if (bvalid && bready)
         begin
            done   <= 1'b1;
            b_resp <= bresp;
            b_id   <= bid;
         end
         else if (wr_ctrl && cfg_wdata_q[axi_tst_pkg::CTRL_DONE_BIT])
            done <= 1'b0;
      end

   always_ff @(posedge clk)
      if (!sync_rst_n)
      begin
         rd_hit <= 1'b0;
         rdata  <= '0;
      end
      else
      begin
         rd_hit <= 1'b1;
         case (cfg_addr_q)
            axi_tst_pkg::REG_B_CTRL: rdata <= {28'd0, b_resp, done, bready};
            axi_tst_pkg::REG_B_ID:   rdata <= axi_tst_pkg::cfg_word_t'(b_id);
            default:
            begin
               rd_hit <= 1'b0;
               rdata  <= '0;
            end
         endcase
      end

endmodule

// ==== axi_tst_cfg_port.sv ====
`timescale 1ns/1ns
module axi_tst_cfg_port
(
   input  logic                   clk,
   input  logic                   sync_rst_n,
   input  axi_tst_pkg::cfg_word_t cfg_addr,
   input  axi_tst_pkg::cfg_word_t cfg_wdata,
   input  logic                   cfg_wr,
   input  logic                   cfg_rd,
   input  axi_tst_pkg::cfg_word_t aw_rdata,
   input  logic                   aw_rd_hit,
   input  axi_tst_pkg::cfg_word_t w_rdata,
   input  logic                   w_rd_hit,
   input  axi_tst_pkg::cfg_word_t b_rdata,
   input  logic                   b_rd_hit,
   input  axi_tst_pkg::cfg_word_t ar_rdata,
   input  logic                   ar_rd_hit,
   input  axi_tst_pkg::cfg_word_t r_rdata,
   input  logic                   r_rd_hit,
   output axi_tst_pkg::cfg_addr_t cfg_addr_q,
   output axi_tst_pkg::cfg_word_t cfg_wdata_q,
   output logic                   wr_stb,
   output logic                   rd_stb,
   output logic                   tst_cfg_ack,
   output axi_tst_pkg::cfg_word_t tst_cfg_rdata
);

   typedef enum logic [1:0] {ST_IDLE, ST_DECODE, ST_STROBE} port_state_t;

   port_state_t            state;
   logic                   cmd_rd;
   axi_tst_pkg::cfg_word_t sel_rdata;

   // Capture, then one cycle for the channels to register readback, then strobe
   always_ff @(posedge clk)
      if (!sync_rst_n)
      begin
         state       <= ST_IDLE;
         cmd_rd      <= 1'b0;
         cfg_addr_q  <= '0;
         cfg_wdata_q <= '0;
      end
      else
      begin
         case (state)
            ST_IDLE:
               if (cfg_wr || cfg_rd)
               begin
                  state       <= ST_DECODE;
                  cmd_rd      <= !cfg_wr;
                  cfg_addr_q  <= cfg_addr[axi_tst_pkg::CFG_ADDR_WIDTH-1:0];
                  cfg_wdata_q <= cfg_wdata;
               end
            ST_DECODE:
               state <= ST_STROBE;
            default:
               state <= ST_IDLE;
         endcase
      end

   assign wr_stb = (state == ST_STROBE) && !cmd_rd;
   assign rd_stb = (state == ST_STROBE) && cmd_rd;

   // Only one channel claims a given offset
   always_comb
      if (aw_rd_hit)
         sel_rdata = aw_rdata;
      else if (w_rd_hit)
         sel_rdata = w_rdata;
      else if (b_rd_hit)
         sel_rdata = b_rdata;
      else if (ar_rd_hit)
         sel_rdata = ar_rdata;
      else if (r_rd_hit)
         sel_rdata = r_rdata;
      else
         sel_rdata = axi_tst_pkg::RDATA_UNMAPPED;

   // Ack and readback land together, on the edge that ends the strobe
   always_ff @(posedge clk)
      if (!sync_rst_n)
      begin
         tst_cfg_ack   <= 1'b0;
         tst_cfg_rdata <= '0;
      end
      else
      begin
         tst_cfg_ack <= (state == ST_STROBE);
         if (state == ST_STROBE)
            tst_cfg_rdata <= sel_rdata;
      end

   ack_one_cycle: assert property (@(posedge clk) disable iff (!sync_rst_n)
      tst_cfg_ack |=> !tst_cfg_ack);

endmodule

// ==== axi_tst_pkg.sv ====
package axi_tst_pkg;

   // Sizes
   localparam int DATA_WIDTH     = 128;
   localparam int NUM_DW         = DATA_WIDTH / 32;
   localparam int ADDR_WIDTH     = 32;
   localparam int LEN_WIDTH      = 8;
   localparam int ID_WIDTH       = 5;
   localparam int CFG_ADDR_WIDTH = 8;

   typedef logic [31:0]               cfg_word_t;
   typedef logic [CFG_ADDR_WIDTH-1:0] cfg_addr_t;
   typedef logic [ADDR_WIDTH-1:0]     axi_addr_t;
   typedef logic [LEN_WIDTH-1:0]      axi_len_t;
   typedef logic [ID_WIDTH-1:0]       axi_id_t;
   typedef logic [DATA_WIDTH-1:0]     axi_data_t;
   typedef logic [DATA_WIDTH/8-1:0]   axi_strb_t;
   typedef logic [1:0]                axi_resp_t;
   typedef logic [15:0]               dw_index_t;

   // Address channel bases and offsets within a channel
   localparam cfg_addr_t AW_BASE    = 8'h00;
   localparam cfg_addr_t AR_BASE    = 8'h60;
   localparam cfg_addr_t OFS_CTRL   = 8'h0;
   localparam cfg_addr_t OFS_ADDR   = 8'h4;
   localparam cfg_addr_t OFS_LEN_ID = 8'hC;

   localparam cfg_addr_t REG_W_CTRL  = 8'h20;
   localparam cfg_addr_t REG_W_INDEX = 8'h24;
   localparam cfg_addr_t REG_W_DATA  = 8'h28;
   localparam cfg_addr_t REG_W_STRB  = 8'h2C;
   localparam cfg_addr_t REG_W_ID    = 8'h34;
   localparam cfg_addr_t REG_B_CTRL  = 8'h40;
   localparam cfg_addr_t REG_B_ID    = 8'h44;
   localparam cfg_addr_t REG_R_CTRL  = 8'h80;
   localparam cfg_addr_t REG_R_INDEX = 8'h84;
   localparam cfg_addr_t REG_R_DATA  = 8'h88;
   localparam cfg_addr_t REG_R_ID    = 8'h8C;

   // Control register bits
   localparam int CTRL_SET_BIT  = 0;
   localparam int CTRL_DONE_BIT = 1;
   localparam int W_LAST_BIT    = 4;

   localparam cfg_word_t RDATA_UNMAPPED = 32'hdeaddead;

endpackage

// ==== axi_tst_rdata_chan.sv ====
`timescale 1ns/1ns
module axi_tst_rdata_chan
(
   input  logic                   clk,
   input  logic                   sync_rst_n,
   input  axi_tst_pkg::cfg_addr_t cfg_addr_q,
   input  axi_tst_pkg::cfg_word_t cfg_wdata_q,
   input  logic                   wr_stb,
   input  logic                   rd_stb,
   input  logic                   rvalid,
   input  axi_tst_pkg::axi_data_t rdata_in,
   input  axi_tst_pkg::axi_resp_t rresp,
   input  logic                   rlast,
   input  axi_tst_pkg::axi_id_t   rid,
   output logic                   rready,
   output axi_tst_pkg::cfg_word_t rdata,
   output logic                   rd_hit
);

   logic                   done;
   logic                   wr_ctrl;
   logic                   in_range;
   axi_tst_pkg::dw_index_t r_index;
   axi_tst_pkg::axi_data_t r_data;
   axi_tst_pkg::axi_resp_t r_resp;
   logic                   r_last;
   axi_tst_pkg::axi_id_t   r_id;

   assign wr_ctrl  = wr_stb && (cfg_addr_q == axi_tst_pkg::REG_R_CTRL);
   assign in_range = r_index < axi_tst_pkg::dw_index_t'(axi_tst_pkg::NUM_DW);

   always_ff @(posedge clk)
      if (!sync_rst_n)
      begin
         rready <= 1'b0;
         done   <= 1'b0;
         r_data <= '0;
         r_resp <= '0;
         r_last <= 1'b0;
         r_id   <= '0;
      end
      else
      begin
         if (wr_ctrl && cfg_wdata_q[axi_tst_pkg::CTRL_SET_BIT])
            rready <= 1'b1;
         else if (rvalid && rready)
            rready <= 1'b0;
         if (rvalid && rready)
         begin
            done   <= 1'b1;
            r_data <= rdata_in;
            r_resp <= rresp;
            r_last <= rlast;
            r_id   <= rid;
         end
         else if (wr_ctrl && cfg_wdata_q[axi_tst_pkg::CTRL_DONE_BIT])
            done <= 1'b0;
      end

   // A host read of the data register returns the current word, then steps once
   always_ff @(posedge clk)
      if (!sync_rst_n)
         r_index <= '0;
      else if (wr_stb && (cfg_addr_q == axi_tst_pkg::REG_R_INDEX))
         r_index <= axi_tst_pkg::dw_index_t'(cfg_wdata_q);
      else if (rd_stb && (cfg_addr_q == axi_tst_pkg::REG_R_DATA))
         r_index <= r_index + 1'b1;

   always_ff @(posedge clk)
      if (!sync_rst_n)
      begin
         rd_hit <= 1'b0;
         rdata  <= '0;
      end
      else
      begin
         rd_hit <= 1'b1;
         case (cfg_addr_q)
            axi_tst_pkg::REG_R_CTRL:  rdata <= {27'd0, r_last, r_resp, done, rready};
            axi_tst_pkg::REG_R_INDEX: rdata <= axi_tst_pkg::cfg_word_t'(r_index);
            axi_tst_pkg::REG_R_DATA:  rdata <= in_range ? r_data[32*r_index +: 32] : '0;
            axi_tst_pkg::REG_R_ID:    rdata <= axi_tst_pkg::cfg_word_t'(r_id);
            default:
            begin
               rd_hit <= 1'b0;
               rdata  <= '0;
            end
         endcase
      end

endmodule

// ==== axi_tst_wdata_chan.sv ====
`timescale 1ns/1ns
module axi_tst_wdata_chan
(
   input  logic                   clk,
   input  logic                   sync_rst_n,
   input  axi_tst_pkg::cfg_addr_t cfg_addr_q,
   input  axi_tst_pkg::cfg_word_t cfg_wdata_q,
   input  logic                   wr_stb,
   input  logic                   wready,
   output logic                   wvalid,
   output axi_tst_pkg::axi_data_t wdata,
   output axi_tst_pkg::axi_strb_t wstrb,
   output logic                   wlast,
   output axi_tst_pkg::axi_id_t   wid,
   output axi_tst_pkg::cfg_word_t rdata,
   output logic                   rd_hit
);

   logic                   done;
   logic                   wr_ctrl;
   logic                   wr_data;
   logic                   in_range;
   axi_tst_pkg::dw_index_t w_index;

   assign wr_ctrl  = wr_stb && (cfg_addr_q == axi_tst_pkg::REG_W_CTRL);
   assign wr_data  = wr_stb && (cfg_addr_q == axi_tst_pkg::REG_W_DATA);
   assign in_range = w_index < axi_tst_pkg::dw_index_t'(axi_tst_pkg::NUM_DW);

   always_ff @(posedge clk)
      if (!sync_rst_n)
      begin
         wvalid <= 1'b0;
         done   <= 1'b0;
      end
      else
      begin
         if (wr_ctrl && cfg_wdata_q[axi_tst_pkg::CTRL_SET_BIT])
            wvalid <= 1'b1;
         else if (wvalid && wready)
            wvalid <= 1'b0;
         if (wvalid && wready)
            done <= 1'b1;
         else if (wr_ctrl && cfg_wdata_q[axi_tst_pkg::CTRL_DONE_BIT])
            done <= 1'b0;
      end

   // Index steps on every data write, even past the end of the beat
   always_ff @(posedge clk)
      if (!sync_rst_n)
         w_index <= '0;
      else if (wr_stb && (cfg_addr_q == axi_tst_pkg::REG_W_INDEX))
         w_index <= axi_tst_pkg::dw_index_t'(cfg_wdata_q);
      else if (wr_data)
         w_index <= w_index + 1'b1;

   always_ff @(posedge clk)
      if (!sync_rst_n)
      begin
         wdata <= '0;
         wstrb <= '0;
         wlast <= 1'b0;
         wid   <= '0;
      end
      else
      begin
         if (wr_data && in_range)
            wdata[32*w_index +: 32] <= cfg_wdata_q;
         if (wr_ctrl)
            wlast <= cfg_wdata_q[axi_tst_pkg::W_LAST_BIT];
         if (wr_stb && (cfg_addr_q == axi_tst_pkg::REG_W_STRB))
            wstrb <= axi_tst_pkg::axi_strb_t'(cfg_wdata_q);
         if (wr_stb && (cfg_addr_q == axi_tst_pkg::REG_W_ID))
            wid <= axi_tst_pkg::axi_id_t'(cfg_wdata_q);
      end

   always_ff @(posedge clk)
      if (!sync_rst_n)
      begin
         rd_hit <= 1'b0;
         rdata  <= '0;
      end
      else
      begin
         rd_hit <= 1'b1;
         case (cfg_addr_q)
            axi_tst_pkg::REG_W_CTRL:  rdata <= {27'd0, wlast, 2'b00, done, wvalid};
            axi_tst_pkg::REG_W_INDEX: rdata <= axi_tst_pkg::cfg_word_t'(w_index);
            axi_tst_pkg::REG_W_DATA:  rdata <= in_range ? wdata[32*w_index +: 32] : '0;
            axi_tst_pkg::REG_W_STRB:  rdata <= axi_tst_pkg::cfg_word_t'(wstrb);
            axi_tst_pkg::REG_W_ID:    rdata <= axi_tst_pkg::cfg_word_t'(wid);
            default:
            begin
               rd_hit <= 1'b0;
               rdata  <= '0;
            end
         endcase
      end

   wvalid_held: assert property (@(posedge clk) disable iff (!sync_rst_n)
      wvalid && !wready |=> wvalid);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_axi_tst -f axi_tst.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vtb_axi_tst > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

if grep -qx "TEST PASSED" "$log"; then
   exit 0
fi
echo "pass message not found in $log"
exit 1

// ==== tb_axi_tst.sv ====
`timescale 1ns/1ns
module tb_axi_tst;

   typedef enum logic [1:0] {OP_WR, OP_RD, OP_POLL} op_kind_t;

   logic                   clk = 1'b0;
   logic                   sync_rst_n;
   axi_tst_pkg::cfg_word_t cfg_addr;
   axi_tst_pkg::cfg_word_t cfg_wdata;
   logic                   cfg_wr;
   logic                   cfg_rd;
   logic                   tst_cfg_ack;
   axi_tst_pkg::cfg_word_t tst_cfg_rdata;

   logic                   awvalid;
   axi_tst_pkg::axi_addr_t awaddr;
   axi_tst_pkg::axi_len_t  awlen;
   axi_tst_pkg::axi_id_t   awid;
   logic                   awready;
   logic                   wvalid;
   axi_tst_pkg::axi_data_t wdata;
   axi_tst_pkg::axi_strb_t wstrb;
   logic                   wlast;
   axi_tst_pkg::axi_id_t   wid;
   logic                   wready;
   logic                   bvalid;
   axi_tst_pkg::axi_resp_t bresp;
   axi_tst_pkg::axi_id_t   bid;
   logic                   bready;
   logic                   arvalid;
   axi_tst_pkg::axi_addr_t araddr;
   axi_tst_pkg::axi_len_t  arlen;
   axi_tst_pkg::axi_id_t   arid;
   logic                   arready;
   logic                   rvalid;
   axi_tst_pkg::axi_data_t rdata;
   axi_tst_pkg::axi_resp_t rresp;
   logic                   rlast;
   axi_tst_pkg::axi_id_t   rid;
   logic                   rready;

   // Slave responder bookkeeping
   logic                   aw_hs;
   logic                   w_hs;
   logic                   b_hs;
   logic                   ar_hs;
   logic                   r_hs;
   int                     aw_count = 0;
   int                     w_count = 0;
   int                     b_count = 0;
   int                     ar_count = 0;
   int                     r_count = 0;
   int                     aw_wait;
   int                     w_wait;
   int                     ar_wait;
   axi_tst_pkg::axi_addr_t seen_awaddr;
   axi_tst_pkg::axi_len_t  seen_awlen;
   axi_tst_pkg::axi_id_t   seen_awid;
   axi_tst_pkg::axi_data_t seen_wdata;
   axi_tst_pkg::axi_strb_t seen_wstrb;
   logic                   seen_wlast;
   axi_tst_pkg::axi_id_t   seen_wid;
   axi_tst_pkg::axi_addr_t seen_araddr;
   axi_tst_pkg::axi_len_t  seen_arlen;
   axi_tst_pkg::axi_id_t   seen_arid;

   // Host operation table
   int                     step_test[$];
   op_kind_t               step_op[$];
   axi_tst_pkg::cfg_addr_t step_ofs[$];
   axi_tst_pkg::cfg_word_t step_data[$];
   axi_tst_pkg::cfg_word_t step_exp[$];
   axi_tst_pkg::cfg_word_t step_mask[$];

   int                     errors = 0;
   int                     tests_failed = 0;
   int                     cycle_cnt = 0;
   int                     t;

   axi_tst UUT (.*);

   always #2 clk = ~clk;

   always @(posedge clk)
      cycle_cnt <= cycle_cnt + 1;

   task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp_val);
      if (got !== exp_val)
      begin
         $display("ERR time %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp_val);
         errors++;
      end
   endtask

   task automatic add_step(input int test_no, input op_kind_t op,
                           input axi_tst_pkg::cfg_addr_t ofs, input axi_tst_pkg::cfg_word_t data,
                           input axi_tst_pkg::cfg_word_t exp_val,
                           input axi_tst_pkg::cfg_word_t mask);
      step_test.push_back(test_no);
      step_op.push_back(op);
      step_ofs.push_back(ofs);
      step_data.push_back(data);
      step_exp.push_back(exp_val);
      step_mask.push_back(mask);
   endtask

   // Each row holds test, operation, offset, write data, expected read value and compare mask
   // A mask of zero leaves the read value unchecked
   task automatic build_table();
      add_step(1, OP_RD,   8'h00, 32'h0,         32'h0000_0000, 32'hffff_ffff);
      add_step(1, OP_RD,   8'h20, 32'h0,         32'h0000_0000, 32'hffff_ffff);
      add_step(1, OP_RD,   8'h40, 32'h0,         32'h0000_0000, 32'hffff_ffff);
      add_step(1, OP_RD,   8'h60, 32'h0,         32'h0000_0000, 32'hffff_ffff);
      add_step(1, OP_RD,   8'h80, 32'h0,         32'h0000_0000, 32'hffff_ffff);
      add_step(1, OP_RD,   8'h50, 32'h0,         32'hdead_dead, 32'hffff_ffff);
      add_step(2, OP_WR,   8'h04, 32'h1000_0040, 32'h0,         32'h0);
      add_step(2, OP_WR,   8'h0C, 32'h0000_1307, 32'h0,         32'h0);
      add_step(2, OP_WR,   8'h00, 32'h0000_0001, 32'h0,         32'h0);
      add_step(2, OP_POLL, 8'h00, 32'h0,         32'h0000_0002, 32'h0000_0003);
      add_step(2, OP_WR,   8'h00, 32'h0000_0002, 32'h0,         32'h0);
      add_step(2, OP_RD,   8'h00, 32'h0,         32'h0000_0000, 32'hffff_ffff);
      add_step(3, OP_WR,   8'h24, 32'h0000_0000, 32'h0,         32'h0);
      add_step(3, OP_WR,   8'h28, 32'h1111_2222, 32'h0,         32'h0);
      add_step(3, OP_WR,   8'h28, 32'h3333_4444, 32'h0,         32'h0);
      add_step(3, OP_WR,   8'h28, 32'h5555_6666, 32'h0,         32'h0);
      add_step(3, OP_WR,   8'h28, 32'h7777_8888, 32'h0,         32'h0);
      add_step(3, OP_WR,   8'h2C, 32'h0000_ffff, 32'h0,         32'h0);
      add_step(3, OP_WR,   8'h34, 32'h0000_000a, 32'h0,         32'h0);
      add_step(3, OP_WR,   8'h20, 32'h0000_0011, 32'h0,         32'h0);
      add_step(3, OP_POLL, 8'h20, 32'h0,         32'h0000_0012, 32'h0000_0013);
      add_step(3, OP_RD,   8'h24, 32'h0,         32'h0000_0004, 32'hffff_ffff);
      add_step(4, OP_WR,   8'h40, 32'h0000_0001, 32'h0,         32'h0);
      add_step(4, OP_POLL, 8'h40, 32'h0,         32'h0000_0002, 32'h0000_000f);
      add_step(4, OP_RD,   8'h44, 32'h0,         32'h0000_000a, 32'hffff_ffff);
      add_step(5, OP_WR,   8'h64, 32'h2000_0080, 32'h0,         32'h0);
      add_step(5, OP_WR,   8'h6C, 32'h0000_1c00, 32'h0,         32'h0);
      add_step(5, OP_WR,   8'h60, 32'h0000_0001, 32'h0,         32'h0);
      add_step(5, OP_POLL, 8'h60, 32'h0,         32'h0000_0002, 32'h0000_0003);
      add_step(5, OP_WR,   8'h80, 32'h0000_0001, 32'h0,         32'h0);
      add_step(5, OP_POLL, 8'h80, 32'h0,         32'h0000_0012, 32'h0000_001f);
      add_step(5, OP_WR,   8'h84, 32'h0000_0000, 32'h0,         32'h0);
      add_step(5, OP_RD,   8'h88, 32'h0,         32'ha5a5_0000, 32'hffff_ffff);
      add_step(5, OP_RD,   8'h88, 32'h0,         32'ha5a5_0001, 32'hffff_ffff);
      add_step(5, OP_RD,   8'h88, 32'h0,         32'ha5a5_0002, 32'hffff_ffff);
      add_step(5, OP_RD,   8'h88, 32'h0,         32'ha5a5_0003, 32'hffff_ffff);
      add_step(5, OP_RD,   8'h8C, 32'h0,         32'h0000_001c, 32'hffff_ffff);
   endtask

   // Issues one host command and is called one step after a rising edge
   task automatic host_access(input logic is_read, input axi_tst_pkg::cfg_addr_t ofs,
                              input axi_tst_pkg::cfg_word_t data,
                              output axi_tst_pkg::cfg_word_t got, output logic acked);
      int n;
      cfg_addr  = {24'd0, ofs};
      cfg_wdata = data;
      cfg_wr    = !is_read;
      cfg_rd    = is_read;
      @(posedge clk);
      #1;
      cfg_wr = 1'b0;
      cfg_rd = 1'b0;
      n = 0;
      while (!tst_cfg_ack && n < 20)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      acked = tst_cfg_ack;
      got   = tst_cfg_rdata;
      if (!acked)
      begin
         $display("time %0t: no ack within 20 cycles for offset 0x%02h", $time, ofs);
         errors++;
      end
   endtask

   task automatic apply_step(input int i);
      axi_tst_pkg::cfg_word_t got;
      logic                   acked;
      int                     start;
      case (step_op[i])
         OP_WR:
            host_access(1'b0, step_ofs[i], step_data[i], got, acked);
         OP_RD:
         begin
            host_access(1'b1, step_ofs[i], '0, got, acked);
            if (acked)
               check($sformatf("tst_cfg_rdata[0x%02h]", step_ofs[i]),
                     got & step_mask[i], step_exp[i] & step_mask[i]);
         end
         default:
         begin
            start = cycle_cnt;
            host_access(1'b1, step_ofs[i], '0, got, acked);
            while (acked && (got & step_mask[i]) != step_exp[i] && cycle_cnt - start < 100)
               host_access(1'b1, step_ofs[i], '0, got, acked);
            if (acked && (got & step_mask[i]) != step_exp[i])
            begin
               $display("time %0t: offset 0x%02h did not reach 0x%0h within 100 cycles",
                        $time, step_ofs[i], step_exp[i]);
               errors++;
            end
         end
      endcase
   endtask

   // What the slave saw on the AXI side
   task automatic check_slave_side(input int test_no);
      case (test_no)
         2:
         begin
            check("aw handshakes", aw_count, 1);
            check("awaddr", seen_awaddr, 32'h1000_0040);
            check("awlen", seen_awlen, 8'h07);
            check("awid", seen_awid, 5'h13);
         end
         3:
         begin
            check("w handshakes", w_count, 1);
            // Word 0 sits in the low bits of the beat
            check("wdata", seen_wdata,
                  {32'h7777_8888, 32'h5555_6666, 32'h3333_4444, 32'h1111_2222});
            check("wstrb", seen_wstrb, 16'hffff);
            check("wid", seen_wid, 5'h0a);
            check("wlast", seen_wlast, 1'b1);
         end
         4:
            check("b handshakes", b_count, 1);
         5:
         begin
            check("ar handshakes", ar_count, 1);
            check("araddr", seen_araddr, 32'h2000_0080);
            check("arlen", seen_arlen, 8'h00);
            check("arid", seen_arid, 5'h1c);
            check("r handshakes", r_count, 1);
         end
         default: ;
      endcase
   endtask

   function automatic string test_title(input int test_no);
      case (test_no)
         1: return "reset values";
         2: return "AW burst";
         3: return "W beat";
         4: return "B response";
         5: return "AR and R beat";
         default: return "unknown";
      endcase
   endfunction

   task automatic run_test(input int test_no);
      int errs_before;
      errs_before = errors;
      for (int i = 0; i < step_op.size(); i++)
         if (step_test[i] == test_no)
            apply_step(i);
      check_slave_side(test_no);
      if (errors == errs_before)
         $display("test %0d %s: ok", test_no, test_title(test_no));
      else
      begin
         tests_failed++;
         $display("test %0d %s: failed with %0d errors", test_no, test_title(test_no),
                  errors - errs_before);
      end
   endtask

   // Ready comes up a random number of cycles after valid and drops after the handshake
   task automatic pace_ready(input logic hs, input logic valid, inout logic ready,
                             inout int wait_cnt);
      if (hs)
      begin
         ready    = 1'b0;
         wait_cnt = int'($urandom % 4);
      end
      else if (valid && !ready)
      begin
         if (wait_cnt == 0)
            ready = 1'b1;
         else
            wait_cnt = wait_cnt - 1;
      end
   endtask

   // Handshakes are judged mid-cycle, where every level has settled
   always @(negedge clk)
   begin
      aw_hs = awvalid && awready;
      w_hs  = wvalid && wready;
      b_hs  = bvalid && bready;
      ar_hs = arvalid && arready;
      r_hs  = rvalid && rready;
      if (aw_hs)
      begin
         aw_count++;
         seen_awaddr = awaddr;
         seen_awlen  = awlen;
         seen_awid   = awid;
      end
      if (w_hs)
      begin
         w_count++;
         seen_wdata = wdata;
         seen_wstrb = wstrb;
         seen_wlast = wlast;
         seen_wid   = wid;
      end
      if (b_hs)
         b_count++;
      if (ar_hs)
      begin
         ar_count++;
         seen_araddr = araddr;
         seen_arlen  = arlen;
         seen_arid   = arid;
      end
      if (r_hs)
         r_count++;
   end

   // AXI slave responder
   initial
   begin
      int k;
      void'($urandom(12703));
      awready = 1'b0;
      wready  = 1'b0;
      arready = 1'b0;
      bvalid  = 1'b0;
      bresp   = '0;
      bid     = '0;
      rvalid  = 1'b0;
      rdata   = '0;
      rresp   = '0;
      rlast   = 1'b0;
      rid     = '0;
      forever
      begin
         @(posedge clk);
         #1;
         if (!sync_rst_n)
         begin
            awready = 1'b0;
            wready  = 1'b0;
            arready = 1'b0;
            bvalid  = 1'b0;
            rvalid  = 1'b0;
            aw_wait = int'($urandom % 4);
            w_wait  = int'($urandom % 4);
            ar_wait = int'($urandom % 4);
         end
         else
         begin
            pace_ready(aw_hs, awvalid, awready, aw_wait);
            pace_ready(w_hs, wvalid, wready, w_wait);
            pace_ready(ar_hs, arvalid, arready, ar_wait);
            // Write response follows the accepted data beat
            if (b_hs)
               bvalid = 1'b0;
            else if (w_hs)
            begin
               bvalid = 1'b1;
               bresp  = 2'b00;
               bid    = seen_wid;
            end
            if (r_hs)
               rvalid = 1'b0;
            else if (ar_hs)
            begin
               for (k = 0; k < axi_tst_pkg::NUM_DW; k++)
                  rdata[32*k +: 32] = 32'ha5a5_0000 + 32'(k);
               rvalid = 1'b1;
               rresp  = 2'b00;
               rlast  = 1'b1;
               rid    = seen_arid;
            end
         end
      end
   end

   initial
   begin
      sync_rst_n = 1'b0;
      cfg_addr   = '0;
      cfg_wdata  = '0;
      cfg_wr     = 1'b0;
      cfg_rd     = 1'b0;
      build_table();
      repeat (5) @(posedge clk);
      #1;
      sync_rst_n = 1'b1;
      for (t = 1; t <= 5; t++)
         run_test(t);
      $display("tests run %0d, failed %0d, errors %0d", 5, tests_failed, errors);
      if (errors == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule
